// File: rtl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// Local memories, in 32-bit words
`define IMEM_WORDS  32
`define DMEM_WORDS  16

// Word index widths into the memories
`define IMEM_AW     ($clog2(`IMEM_WORDS))
`define DMEM_AW     ($clog2(`DMEM_WORDS))

// First fetch address after reset
`define RESET_PC    32'h0000_0000

// ABI register shown at the top level
`define A0_REG      10

`endif

// File: rtl/rv_isa_pkg.sv
`include "rv_defs.svh"

package rv_isa_pkg;

    // Data and instruction word
    typedef logic [`XLEN-1:0] word_t;

    // Register file index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,  // Signed compare
        ALU_PASS_B = 4'd6   // LUI result
    } alu_op_e;

    // funct3 codes shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

endpackage

// File: rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Write-back bus, also the forward source
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rd1;
        word_t     rd2;
        word_t     imm;
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      branch_ne;  // BNE when set, BEQ otherwise
        logic      jump;
    } decode_to_execute_t;

    typedef struct packed {
        logic      valid;
        word_t     alu_result;
        word_t     store_data;
        word_t     link;       // pc+4 of a JAL
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      is_jump;
    } execute_to_result_t;

endpackage

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            prog_we_i,
    input  logic [`IMEM_AW-1:0]             prog_addr_i,
    input  rv_isa_pkg::word_t               prog_data_i,
    input  logic                            redirect_valid_i,
    input  rv_isa_pkg::word_t               redirect_pc_i,
    input  logic                            halted_i,
    input  rv_pipe_pkg::reg_write_t         wb_i,
    output rv_pipe_pkg::decode_to_execute_t d2e_o,
    output rv_isa_pkg::word_t               a0_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t              pc_q;
    word_t              instr;
    word_t              imem [`IMEM_WORDS];
    word_t              regs [2**`REG_ADDR_W];
    opcode_e            opcode;
    funct3_e            funct3;
    decode_to_execute_t d2e_d;
    decode_to_execute_t d2e_q;

    function automatic alu_op_e arith_op(funct3_e f3, logic sub);
        case (f3)
            F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // Write-through so a result retiring this cycle is seen here
    function automatic word_t reg_read(reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb_i.en && wb_i.rd == addr)
            return wb_i.data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i)
            pc_q <= `RESET_PC;
        else if (redirect_valid_i)
            pc_q <= redirect_pc_i;
        else if (!halted_i)        // Frozen once halted
            pc_q <= pc_q + word_t'(4);
    end

    always_ff @(posedge clk) begin
        if (rst_i && prog_we_i)
            imem[prog_addr_i] <= prog_data_i;
    end

    assign instr  = imem[pc_q[`IMEM_AW+1:2]];
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = funct3_e'(instr[14:12]);

    always_comb begin
        d2e_d       = '0;
        d2e_d.valid = 1'b1;
        d2e_d.pc    = pc_q;
        d2e_d.rs1   = instr[19:15];
        d2e_d.rs2   = instr[24:20];
        d2e_d.rd    = instr[11:7];
        d2e_d.rd1   = reg_read(instr[19:15]);
        d2e_d.rd2   = reg_read(instr[24:20]);
        case (opcode)
            OPC_OP: begin
                d2e_d.alu_op    = arith_op(funct3, instr[30]);
                d2e_d.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                d2e_d.alu_op      = arith_op(funct3, 1'b0);
                d2e_d.alu_src_imm = 1'b1;
                d2e_d.reg_write   = 1'b1;
                d2e_d.imm         = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            OPC_LUI: begin
                d2e_d.alu_op      = ALU_PASS_B;
                d2e_d.alu_src_imm = 1'b1;
                d2e_d.reg_write   = 1'b1;
                d2e_d.imm         = {instr[31:12], 12'b0};
            end
            OPC_LOAD: begin
                d2e_d.alu_src_imm = 1'b1;
                d2e_d.reg_write   = 1'b1;
                d2e_d.mem_read    = 1'b1;
                d2e_d.imm         = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                d2e_d.alu_src_imm = 1'b1;
                d2e_d.mem_write   = 1'b1;
                d2e_d.imm         = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                d2e_d.branch    = 1'b1;
                d2e_d.branch_ne = instr[12];
                d2e_d.imm       = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                                   instr[30:25], instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                d2e_d.jump      = 1'b1;
                d2e_d.reg_write = 1'b1;
                d2e_d.imm       = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                                   instr[20], instr[30:21], 1'b0};
            end
            default: d2e_d.valid = 1'b0;  // Unknown opcode, bubble
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++)
                regs[i] <= '0;
        end else if (wb_i.en && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    always_ff @(posedge clk) begin
        d2e_q <= d2e_d;
        if (rst_i || redirect_valid_i || halted_i)
            d2e_q.valid <= 1'b0;  // Flush the wrong-path fetch
    end

    assign d2e_o = d2e_q;
    assign a0_o  = regs[`A0_REG];

    assert property (@(posedge clk) prog_we_i |-> rst_i);  // Loading only in reset

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                            clk,
    input  logic                            rst_i,
    input  rv_pipe_pkg::decode_to_execute_t d2e_i,
    input  rv_pipe_pkg::reg_write_t         wb_i,
    output logic                            redirect_valid_o,
    output rv_isa_pkg::word_t               redirect_pc_o,
    output logic                            halted_o,
    output rv_pipe_pkg::execute_to_result_t e2r_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t              op_a;
    word_t              rs2_val;
    word_t              op_b;
    word_t              alu_out;
    word_t              target;
    logic               operands_eq;
    logic               taken;
    logic               halt_hit;
    logic               halted_q;
    execute_to_result_t e2r_d;
    execute_to_result_t e2r_q;

    // Result stage value wins over the register read
    function automatic word_t forward(reg_addr_t rs, word_t value, reg_write_t wb);
        if (wb.en && wb.rd != '0 && wb.rd == rs)
            return wb.data;
        return value;
    endfunction

    assign op_a    = forward(d2e_i.rs1, d2e_i.rd1, wb_i);
    assign rs2_val = forward(d2e_i.rs2, d2e_i.rd2, wb_i);
    assign op_b    = d2e_i.alu_src_imm ? d2e_i.imm : rs2_val;

    always_comb begin
        case (d2e_i.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    assign target      = d2e_i.pc + d2e_i.imm;  // Branch and JAL share it
    assign operands_eq = (op_a == rs2_val);
    assign taken       = d2e_i.valid &&
                         (d2e_i.jump || (d2e_i.branch && (operands_eq != d2e_i.branch_ne)));
    assign halt_hit    = d2e_i.valid && d2e_i.jump && (target == d2e_i.pc);

    assign redirect_valid_o = taken;
    assign redirect_pc_o    = target;

    always_ff @(posedge clk) begin
        if (rst_i)
            halted_q <= 1'b0;
        else if (halt_hit)
            halted_q <= 1'b1;
    end

    always_comb begin
        e2r_d.valid      = d2e_i.valid;
        e2r_d.alu_result = alu_out;
        e2r_d.store_data = rs2_val;
        e2r_d.link       = d2e_i.pc + word_t'(4);
        e2r_d.rd         = d2e_i.rd;
        e2r_d.reg_write  = d2e_i.reg_write;
        e2r_d.mem_read   = d2e_i.mem_read;
        e2r_d.mem_write  = d2e_i.mem_write;
        e2r_d.is_jump    = d2e_i.jump;
    end

    always_ff @(posedge clk) begin
        e2r_q <= e2r_d;
        if (rst_i)
            e2r_q.valid <= 1'b0;
    end

    assign e2r_o    = e2r_q;
    assign halted_o = halted_q;

    // Wrong-path fetch never reaches execute
    assert property (@(posedge clk) disable iff (rst_i) redirect_valid_o |=> !d2e_i.valid);

    assert property (@(posedge clk) disable iff (rst_i) halted_o |-> !d2e_i.valid);  // Bubbles only

endmodule

// File: rtl/result_stage.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module result_stage (
    input  logic                            clk,
    input  logic                            rst_i,
    input  rv_pipe_pkg::execute_to_result_t e2r_i,
    output rv_pipe_pkg::reg_write_t         wb_o
);
    import rv_isa_pkg::*;

    word_t               dmem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] dmem_idx;
    word_t               load_data;
    logic                mem_access;

    assign mem_access = e2r_i.valid && (e2r_i.mem_read || e2r_i.mem_write);
    assign dmem_idx   = e2r_i.alu_result[`DMEM_AW+1:2];  // Word address

    always_ff @(posedge clk) begin
        if (e2r_i.valid && e2r_i.mem_write)
            dmem[dmem_idx] <= e2r_i.store_data;
    end

    assign load_data = dmem[dmem_idx];  // Read in the same cycle

    always_comb begin
        wb_o.en = e2r_i.valid && e2r_i.reg_write && !e2r_i.mem_write;
        wb_o.rd = e2r_i.rd;
        if (e2r_i.mem_read)
            wb_o.data = load_data;
        else if (e2r_i.is_jump)
            wb_o.data = e2r_i.link;
        else
            wb_o.data = e2r_i.alu_result;
    end

    // Loads and stores stay aligned and inside the memory
    assert property (@(posedge clk) disable iff (rst_i)
        mem_access |-> e2r_i.alu_result[1:0] == 2'b00 &&
                       e2r_i.alu_result[`XLEN-1:`DMEM_AW+2] == '0);

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module cpu (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                prog_we_i,
    input  logic [`IMEM_AW-1:0] prog_addr_i,
    input  rv_isa_pkg::word_t   prog_data_i,
    output logic                halted_o,
    output rv_isa_pkg::word_t   a0_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    decode_to_execute_t d2e;
    execute_to_result_t e2r;
    reg_write_t         wb;     // Register write and forward source
    logic               redirect_valid;
    word_t              redirect_pc;

    decode_stage pipeline_decode_stage (
        .clk(clk),
        .rst_i(rst_i),
        .prog_we_i(prog_we_i),
        .prog_addr_i(prog_addr_i),
        .prog_data_i(prog_data_i),
        .redirect_valid_i(redirect_valid),
        .redirect_pc_i(redirect_pc),
        .halted_i(halted_o),
        .wb_i(wb),
        .d2e_o(d2e),
        .a0_o(a0_o)
    );

    execute_stage pipeline_execute_stage (
        .clk(clk),
        .rst_i(rst_i),
        .d2e_i(d2e),
        .wb_i(wb),
        .redirect_valid_o(redirect_valid),
        .redirect_pc_o(redirect_pc),
        .halted_o(halted_o),
        .e2r_o(e2r)
    );

    result_stage pipeline_result_stage (
        .clk(clk),
        .rst_i(rst_i),
        .e2r_i(e2r),
        .wb_o(wb)
    );

endmodule

// File: test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // 20 ns period
    end

    // Power-up reset
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: test/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker #(
    parameter int NAME_LEN   = 12,
    parameter int HALT_LIMIT = 56
) (
    input  logic                  clk,
    input  logic                  start_i,
    input  logic [8*NAME_LEN-1:0] name_i,
    input  rv_isa_pkg::word_t     expected_i,
    input  logic                  halted_i,
    input  rv_isa_pkg::word_t     a0_i,
    input  logic                  finish_i,
    output logic                  done_o,
    output logic                  summary_o,
    output int                    pass_count_o,
    output int                    fail_count_o
);
    import rv_isa_pkg::*;

    task automatic check_run();
        int    waited;
        logic  ok;
        logic  steady;
        word_t final_a0;
        ok     = 1'b1;
        steady = 1'b1;
        waited = 0;
        if (halted_i) begin
            $display("Test %0s: halted_o was already high right after reset", name_i);
            ok = 1'b0;
        end
        while (!halted_i && waited < HALT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!halted_i) begin
            $display("Test %0s: the core never raised halted_o", name_i);
            ok = 1'b0;
        end else begin
            @(posedge clk);
            final_a0 = a0_i;  // Last write-back has landed
            repeat (4) begin
                @(posedge clk);
                if (a0_i !== final_a0 || !halted_i)
                    steady = 1'b0;
            end
            if (!steady) begin
                $display("Test %0s: a0_o or halted_o changed after the halt", name_i);
                ok = 1'b0;
            end
            if (final_a0 !== expected_i) begin
                $display("Error: %0s expected %h actual %h", name_i, expected_i, final_a0);
                ok = 1'b0;
            end
        end
        if (ok) begin
            $display("Passed %0s: a0 = %h", name_i, final_a0);
            pass_count_o++;
        end else begin
            fail_count_o++;
        end
        done_o <= 1'b1;
    endtask

    initial begin
        pass_count_o = 0;
        fail_count_o = 0;
        done_o       = 1'b0;
        summary_o    = 1'b0;
        forever begin
            @(posedge clk);
            done_o <= 1'b0;
            if (finish_i && !summary_o) begin
                $display("Tests passed: %0d, failed: %0d", pass_count_o, fail_count_o);
                summary_o <= 1'b1;
            end else if (start_i) begin
                check_run();
            end
        end
    end

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module cpu_tb;
    import rv_isa_pkg::*;

    localparam int    NUM_TESTS  = 6;
    localparam int    SLOTS      = 12;
    localparam int    NAME_LEN   = 12;
    localparam int    RUN_LIMIT  = 3 * SLOTS + 20;
    localparam int    MAX_CYCLES = 16 + NUM_TESTS * (16 + SLOTS + 2 + RUN_LIMIT);
    localparam int    ADDR_W     = `IMEM_AW;
    localparam word_t HALT       = 32'h0000_006f;  // JAL x0, 0

    typedef logic [ADDR_W-1:0] imem_addr_t;

    typedef struct packed {
        logic [8*NAME_LEN-1:0]       name;
        logic [SLOTS-1:0][`XLEN-1:0] prog;
        word_t                       expected;
    } test_entry_t;

    test_entry_t           tests [NUM_TESTS];
    int                    n_tests = 0;
    int                    n_slots = 0;
    int                    cycles  = 0;
    logic                  clk;
    logic                  por_rst;
    logic                  test_rst;
    logic                  rst;
    logic                  prog_we;
    imem_addr_t            prog_addr;
    word_t                 prog_data;
    logic                  halted;
    word_t                 a0;
    logic                  start;
    logic                  finish;
    logic [8*NAME_LEN-1:0] cur_name;
    word_t                 cur_expected;
    logic                  done;
    logic                  summary;
    int                    pass_count;
    int                    fail_count;

    clock_gen clock_gen0 (.clk_o(clk), .rst_o(por_rst));

    assign rst = por_rst | test_rst;

    cpu dut0 (
        .clk(clk),
        .rst_i(rst),
        .prog_we_i(prog_we),
        .prog_addr_i(prog_addr),
        .prog_data_i(prog_data),
        .halted_o(halted),
        .a0_o(a0)
    );

    cpu_checker #(.NAME_LEN(NAME_LEN), .HALT_LIMIT(RUN_LIMIT)) checker0 (
        .clk(clk),
        .start_i(start),
        .name_i(cur_name),
        .expected_i(cur_expected),
        .halted_i(halted),
        .a0_i(a0),
        .finish_i(finish),
        .done_o(done),
        .summary_o(summary),
        .pass_count_o(pass_count),
        .fail_count_o(fail_count)
    );

    // RV32I encoders
    function automatic word_t r_op(int f3, int rd, int rs1, int rs2, int sub);
        return {1'b0, 1'(sub), 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction

    function automatic word_t i_op(int opc, int f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
    endfunction

    function automatic word_t sw_op(int rs2, int rs1, int imm);
        logic [11:0] ofs;
        ofs = 12'(imm);
        return {ofs[11:5], 5'(rs2), 5'(rs1), 3'b010, ofs[4:0], 7'h23};
    endfunction

    function automatic word_t b_op(int ne, int rs1, int rs2, int imm);
        logic [12:0] ofs;
        ofs = 13'(imm);
        return {ofs[12], ofs[10:5], 5'(rs2), 5'(rs1), 2'b00, 1'(ne), ofs[4:1], ofs[11], 7'h63};
    endfunction

    function automatic word_t lui_op(int rd, int imm);
        return {20'(imm), 5'(rd), 7'h37};
    endfunction

    task automatic new_test(input logic [8*NAME_LEN-1:0] name, input word_t expected);
        tests[n_tests].name     = name;
        tests[n_tests].expected = expected;
        tests[n_tests].prog     = {SLOTS{HALT}};  // Unused slots halt
        n_tests++;
        n_slots = 0;
    endtask

    task automatic put(input word_t instr);
        tests[n_tests-1].prog[n_slots] = instr;
        n_slots++;
    endtask

    task automatic build_table();
        new_test("alu_reg", 32'd9);
        put(i_op(7'h13, 0, 1, 0, -7));
        put(i_op(7'h13, 0, 2, 0, 5));
        put(r_op(2, 3, 1, 2, 0));   // slt, -7 < 5
        put(r_op(0, 4, 2, 1, 1));   // sub gives 12
        put(r_op(4, 5, 4, 2, 0));
        put(r_op(6, 6, 5, 3, 0));
        put(r_op(7, 7, 6, 4, 0));
        put(r_op(0, 10, 7, 3, 0));
        new_test("alu_imm", 32'h0000_079c);
        put(i_op(7'h13, 0, 10, 0, 100));
        put(i_op(7'h13, 4, 10, 10, -1));    // -101
        put(i_op(7'h13, 2, 11, 10, -100));
        put(i_op(7'h13, 7, 10, 10, 255));
        put(i_op(7'h13, 6, 10, 10, 'h700));
        put(r_op(0, 10, 10, 11, 0));
        new_test("load_store", 32'd130);
        put(i_op(7'h13, 0, 3, 0, 7));
        put(i_op(7'h13, 0, 1, 0, 123));
        put(sw_op(1, 0, 8));
        put(i_op(7'h03, 2, 2, 0, 8));       // lw right after the store
        put(r_op(0, 10, 2, 3, 0));
        new_test("branch", 32'd5);
        put(i_op(7'h13, 0, 10, 0, 1));
        put(i_op(7'h13, 0, 1, 0, 3));
        put(b_op(0, 1, 1, 8));              // beq taken
        put(i_op(7'h13, 0, 10, 10, 16));
        put(b_op(1, 1, 0, 8));              // bne taken
        put(i_op(7'h13, 0, 10, 10, 32));
        put(b_op(0, 1, 0, 8));              // beq falls through
        put(i_op(7'h13, 0, 10, 10, 4));
        new_test("lui_ori", 32'h1234_5678);
        put(lui_op(10, 'h12345));
        put(i_op(7'h13, 6, 10, 10, 'h678));
        new_test("reset_clear", 32'd0);     // Only the halt
    endtask

    initial begin
        test_rst     = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        start        = 1'b0;
        finish       = 1'b0;
        cur_name     = '0;
        cur_expected = '0;
        build_table();
        for (int t = 0; t < n_tests; t++) begin
            @(posedge clk);
            test_rst <= 1'b1;
            for (int s = 0; s < SLOTS; s++) begin
                @(posedge clk);
                prog_we   <= 1'b1;
                prog_addr <= imem_addr_t'(s);
                prog_data <= tests[t].prog[s];
            end
            @(posedge clk);
            prog_we <= 1'b0;
            repeat (16) @(posedge clk);
            test_rst     <= 1'b0;
            cur_name     <= tests[t].name;
            cur_expected <= tests[t].expected;
            start        <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            do @(posedge clk); while (!done);
        end
        finish <= 1'b1;
        do @(posedge clk); while (!summary);
        if (fail_count == 0 && pass_count == n_tests)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation hung: the tests did not finish within %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/cpu.sv
test/clock_gen.sv
test/cpu_checker.sv
test/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb \
    -f filelist.f -Mdir obj_dir -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpu_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
